// File: isf.f
+incdir+verif
rtl/isf_pkg.sv
rtl/isf_ib_fifo.sv
rtl/isf_tlv_decode.sv
rtl/isf_tlv_exec.sv
rtl/isf_ob_result.sv
rtl/isf_core.sv
verif/isf_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = isf_tb
FILELIST = isf.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: verif/isf_tb_ref.svh
`ifndef ISF_TB_REF_SVH
`define ISF_TB_REF_SVH

// expected output beat plus the command flag that the stat strobes must show.
typedef struct packed {
  isf_beat_t beat;
  logic      cmd;
} exp_t;

exp_t exp_q [$];
int   eot_exp = 0;
int   cmd_exp = 0;

// 32-bit LCG. the upper bits have the longer period.
function automatic logic [15:0] lcg16(inout int unsigned s);
  s = s * 32'd1103515245 + 32'd12345;
  return s[30:15];
endfunction

// output beat as the filter rules define it for one input beat.
function automatic exp_t expect_beat(isf_beat_t b, logic dis);
  exp_t e;
  e.beat = b;
  e.cmd  = b.sot && (b.data[7:0] == TLV_CMD);
  if (b.sot && dis) begin
    e.beat.data[DBG_BIT] = 1'b0;
  end
  return e;
endfunction

function automatic bcnt_t strb_bytes(strb_t s);
  bcnt_t n;
  n = '0;
  for (int i = 0; i < STRB_W; i++) begin
    if (s[i]) begin
      n = n + bcnt_t'(1);
    end
  end
  return n;
endfunction

function automatic logic trig_matches(data_t d, data_t mask, data_t match);
  return (d & mask) == (match & mask);
endfunction

task automatic push_expected(isf_beat_t b, logic dis);
  exp_t e;
  e = expect_beat(b, dis);
  exp_q.push_back(e);
  eot_exp = eot_exp + int'(b.eot);
  cmd_exp = cmd_exp + int'(e.cmd);
endtask

`endif

// File: verif/isf_tb.sv
`timescale 1ns/100ps

module isf_tb import isf_pkg::*;;

  logic        clk;
  logic        arst_n;
  isf_beat_t   ib_beat;
  logic        ib_credit;
  isf_beat_t   ob_beat;
  logic        ob_credit = 1'b0;
  logic        dbg_cmd_disable;
  data_t       trig_mask;
  data_t       trig_match;
  isf_stat_t   ib_stat;
  logic        trig_hit;
  data_t       trig_cap;
  logic        prot_err;
  logic        ovfl;

  int unsigned tx_seed = 75;
  int unsigned rx_seed = 75;
  int          cyc = 0;
  int          sent = 0;
  int          ret_total = 0;
  int          frame_cnt = 0;
  int          cmd_cnt = 0;
  int          ob_cnt = OB_CREDITS;
  int          owed = 0;
  int          stall_until = 0;
  int          ret_sched [8] = '{default: 0};
  int          fails [1:6] = '{default: 0};
  int          n_pass = 0;
  int          n_fail = 0;
  logic        ref_hit = 1'b0;
  data_t       ref_cap = '0;

  `include "isf_tb_ref.svh"

  isf_core dut0 (
    .clk             (clk),
    .arst_n          (arst_n),
    .ib_beat         (ib_beat),
    .ib_credit       (ib_credit),
    .ob_beat         (ob_beat),
    .ob_credit       (ob_credit),
    .dbg_cmd_disable (dbg_cmd_disable),
    .trig_mask       (trig_mask),
    .trig_match      (trig_match),
    .ib_stat         (ib_stat),
    .trig_hit        (trig_hit),
    .trig_cap        (trig_cap),
    .prot_err        (prot_err),
    .ovfl            (ovfl)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic data_t rand_data();
    data_t d;
    d[15:0]  = lcg16(tx_seed);
    d[31:16] = lcg16(tx_seed);
    d[47:32] = lcg16(tx_seed);
    d[63:48] = lcg16(tx_seed);
    return d;
  endfunction

  // the sender may only use credits it holds, refilled by ib_credit pulses.
  task automatic send_beat(input isf_beat_t b);
    @(negedge clk);
    while (IB_DEPTH - sent + ret_total <= 0) begin
      ib_beat = '0;
      @(negedge clk);
    end
    ib_beat = b;
    sent++;
    push_expected(b, dbg_cmd_disable);
  endtask

  // a beat at index pos, when pos is not negative, carries the data d.
  task automatic send_frame(input int pos, input data_t d);
    isf_beat_t b;
    tlv_type_t t;
    int        n;
    n = 1 + int'(lcg16(tx_seed)) % 6;
    if (pos >= n) begin
      n = pos + 1;
    end
    for (int i = 0; i < n; i++) begin
      b      = '0;
      b.data = rand_data();
      if (i == 0) begin
        t = tlv_type_t'(lcg16(tx_seed));
        if (int'(lcg16(tx_seed)) % 3 == 0) begin
          t = TLV_CMD;
        end else if (t == TLV_CMD) begin
          t = 8'h02;
        end
        b.data[7:0] = t;
      end
      if (i == pos) begin
        b.data = d;
      end
      b.strb  = (i == n - 1) ? strb_t'(lcg16(tx_seed)) : '1;
      b.sot   = (i == 0);
      b.eot   = (i == n - 1);
      b.valid = 1'b1;
      send_beat(b);
    end
  endtask

  task automatic drain();
    @(negedge clk);
    ib_beat = '0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
  endtask

  task automatic report(input int num, input string name, input int nerr);
    if (nerr == 0) begin
      $display("test %0d %s: ok", num, name);
      n_pass++;
    end else begin
      $display("test %0d %s: %0d errors", num, name, nerr);
      n_fail++;
    end
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (arst_n) begin
      ret_total = ret_total + int'(ib_credit);
      frame_cnt = frame_cnt + int'(ib_stat.frame_stb);
      cmd_cnt   = cmd_cnt + int'(ib_stat.cmd_stb);
    end
  end

  // receiver model and compare. each beat sent schedules one credit return.
  always @(negedge clk) begin : compare
    exp_t e;
    int   slot;
    if (arst_n && ob_beat.valid) begin
      if (ob_cnt == 0) begin
        $display("credit rule broken: ob_beat valid at %0t with no receiver credit", $time);
        fails[2]++;
      end else begin
        ob_cnt = ob_cnt - 1;
      end
      slot = (cyc + 1 + int'(lcg16(rx_seed)) % 5) % 8;
      ret_sched[slot]++;
      if (exp_q.size() == 0) begin
        $display("unexpected output beat at %0t with nothing sent for it", $time);
        fails[1]++;
      end else begin
        e = exp_q.pop_front();
        if (ob_beat !== e.beat) begin
          $display("Fail at %0t: ob_beat got %h expected %h", $time, ob_beat, e.beat);
          fails[1]++;
        end
        if (ib_stat.bytes_stb !== 1'b1) begin
          $display("Fail at %0t: ib_stat.bytes_stb got %b expected 1", $time,
                   ib_stat.bytes_stb);
          fails[3]++;
        end
        if (ib_stat.bytes_amt !== strb_bytes(e.beat.strb)) begin
          $display("Fail at %0t: ib_stat.bytes_amt got %0d expected %0d", $time,
                   ib_stat.bytes_amt, strb_bytes(e.beat.strb));
          fails[3]++;
        end
        if (ib_stat.frame_stb !== e.beat.eot) begin
          $display("Fail at %0t: ib_stat.frame_stb got %b expected %b", $time,
                   ib_stat.frame_stb, e.beat.eot);
          fails[4]++;
        end
        if (ib_stat.cmd_stb !== e.cmd) begin
          $display("Fail at %0t: ib_stat.cmd_stb got %b expected %b", $time,
                   ib_stat.cmd_stb, e.cmd);
          fails[4]++;
        end
        if (!ref_hit && trig_matches(e.beat.data, trig_mask, trig_match)) begin
          ref_hit = 1'b1;
          ref_cap = e.beat.data;
        end
      end
    end
    slot            = cyc % 8;
    owed            = owed + ret_sched[slot];
    ret_sched[slot] = 0;
    if (arst_n && owed > 0 && cyc >= stall_until) begin
      ob_credit = 1'b1;
      owed--;
      ob_cnt++;
    end else begin
      ob_credit = 1'b0;
    end
  end

  initial begin : watchdog
    @(negedge clk);
    while (cyc <= 40 * sent + 500) begin
      @(negedge clk);
    end
    $display("timeout after %0d cycles with %0d beats sent", cyc, sent);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    isf_beat_t b;
    data_t     d;
    arst_n          = 1'b0;
    ib_beat         = '0;
    dbg_cmd_disable = 1'b0;
    trig_match      = rand_data();
    trig_mask       = rand_data() | 64'hff00_0000_0000_0ff0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    repeat (40) send_frame(-1, '0);
    drain();
    dbg_cmd_disable = 1'b1;
    // credits stop coming back for a while, so the whole path backs up.
    stall_until = cyc + 200;
    repeat (40) send_frame(-1, '0);
    drain();
    report(1, "order and debug masking", fails[1]);

    if (trig_hit !== 1'b0 || ref_hit) begin
      $display("trigger fired before the trigger stream was sent");
      fails[5]++;
    end
    for (int f = 0; f < 6; f++) begin
      d = (trig_match & trig_mask) | (rand_data() & ~trig_mask);
      send_frame((f == 1 || f == 4) ? 1 : -1, d);
    end
    drain();
    if (!ref_hit) begin
      $display("reference found no matching beat in the trigger stream");
      fails[5]++;
    end
    if (trig_hit !== 1'b1) begin
      $display("Fail at %0t: trig_hit got %b expected 1", $time, trig_hit);
      fails[5]++;
    end
    if (trig_cap !== ref_cap) begin
      $display("Fail at %0t: trig_cap got %h expected %h", $time, trig_cap, ref_cap);
      fails[5]++;
    end
    report(5, "debug trigger", fails[5]);

    if (prot_err !== 1'b0) begin
      $display("Fail at %0t: prot_err got %b expected 0", $time, prot_err);
      fails[6]++;
    end
    b       = '0;
    b.data  = rand_data();
    b.strb  = '1;
    b.eot   = 1'b1;
    b.valid = 1'b1;
    send_beat(b);
    drain();
    if (prot_err !== 1'b1) begin
      $display("Fail at %0t: prot_err got %b expected 1", $time, prot_err);
      fails[6]++;
    end
    report(6, "protocol check", fails[6]);

    if (ret_total != sent) begin
      $display("Fail at %0t: ib_credit pulses got %0d expected %0d", $time, ret_total, sent);
      fails[2]++;
    end
    if (ovfl !== 1'b0) begin
      $display("Fail at %0t: ovfl got %b expected 0", $time, ovfl);
      fails[2]++;
    end
    report(2, "credit flow", fails[2]);
    report(3, "byte statistics", fails[3]);
    if (frame_cnt != eot_exp) begin
      $display("Fail at %0t: frame_stb count got %0d expected %0d", $time, frame_cnt, eot_exp);
      fails[4]++;
    end
    if (cmd_cnt != cmd_exp) begin
      $display("Fail at %0t: cmd_stb count got %0d expected %0d", $time, cmd_cnt, cmd_exp);
      fails[4]++;
    end
    report(4, "frame and command strobes", fails[4]);

    $display("summary: %0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/isf_core.sv
`timescale 1ns/100ps

module isf_core import isf_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  isf_beat_t ib_beat,
  output logic      ib_credit,
  output isf_beat_t ob_beat,
  input  logic      ob_credit,
  input  logic      dbg_cmd_disable,
  input  data_t     trig_mask,
  input  data_t     trig_match,
  output isf_stat_t ib_stat,
  output logic      trig_hit,
  output data_t     trig_cap,
  output logic      prot_err,
  output logic      ovfl
);

  isf_beat_t head;
  logic      not_empty;
  logic      pop;
  isf_cls_t  cls;
  isf_beat_t x_beat;
  logic      x_hdr;
  logic      x_cmd;
  logic      advance;

  isf_ib_fifo u_isf_ib_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_beat   (ib_beat),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .credit    (ib_credit),
    .ovfl      (ovfl)
  );

  isf_tlv_decode u_isf_tlv_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .head      (head),
    .not_empty (not_empty),
    .advance   (advance),
    .pop       (pop),
    .cls       (cls)
  );

  isf_tlv_exec u_isf_tlv_exec (
    .clk             (clk),
    .arst_n          (arst_n),
    .cls             (cls),
    .advance         (advance),
    .dbg_cmd_disable (dbg_cmd_disable),
    .trig_mask       (trig_mask),
    .trig_match      (trig_match),
    .x_beat          (x_beat),
    .x_hdr           (x_hdr),
    .x_cmd           (x_cmd),
    .trig_hit        (trig_hit),
    .trig_cap        (trig_cap),
    .prot_err        (prot_err)
  );

  isf_ob_result u_isf_ob_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .x_beat    (x_beat),
    .x_hdr     (x_hdr),
    .x_cmd     (x_cmd),
    .ob_credit (ob_credit),
    .advance   (advance),
    .ob_beat   (ob_beat),
    .ib_stat   (ib_stat)
  );

endmodule

// File: rtl/isf_ob_result.sv
`timescale 1ns/100ps

module isf_ob_result import isf_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  isf_beat_t x_beat,
  input  logic      x_hdr,
  input  logic      x_cmd,
  input  logic      ob_credit,
  output logic      advance,
  output isf_beat_t ob_beat,
  output isf_stat_t ib_stat
);

  ob_cnt_t cnt;
  logic    send;

  // the whole pipeline stalls when no credit is left toward the receiver.
  assign advance = (cnt != '0);
  assign send    = advance && x_beat.valid;

  // a send and a returned credit in the same cycle cancel out.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= ob_cnt_t'(OB_CREDITS);
    end else begin
      cnt <= cnt - ob_cnt_t'(send) + ob_cnt_t'(ob_credit);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ob_beat <= '0;
    end else begin
      ob_beat       <= x_beat;
      ob_beat.valid <= send;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ib_stat <= '0;
    end else begin
      ib_stat.bytes_stb <= send;
      ib_stat.bytes_amt <= send ? bcnt_t'($countones(x_beat.strb)) : '0;
      ib_stat.frame_stb <= send && x_beat.eot;
      ib_stat.cmd_stb   <= send && x_hdr && x_cmd;
    end
  end

  // the receiver may not hand back more credits than it was given.
  a_cnt_range: assert property (
    @(posedge clk) disable iff (!arst_n) cnt <= ob_cnt_t'(OB_CREDITS)
  ) else $error("outbound credit count above its initial value");

endmodule

// File: rtl/isf_tlv_exec.sv
`timescale 1ns/100ps

module isf_tlv_exec import isf_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  isf_cls_t  cls,
  input  logic      advance,
  input  logic      dbg_cmd_disable,
  input  data_t     trig_mask,
  input  data_t     trig_match,
  output isf_beat_t x_beat,
  output logic      x_hdr,
  output logic      x_cmd,
  output logic      trig_hit,
  output data_t     trig_cap,
  output logic      prot_err
);

  isf_beat_t beat_d;
  logic      match;
  logic      load;

  assign load = advance && cls.beat.valid;

  // headers lose their debug request while debug commands are disabled.
  always_comb begin
    beat_d = cls.beat;
    if (cls.is_hdr && dbg_cmd_disable) begin
      beat_d.data[DBG_BIT] = 1'b0;
    end
  end

  // only the bits under the mask take part in the compare.
  assign match = ((beat_d.data ^ trig_match) & trig_mask) == '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x_beat <= '0;
      x_hdr  <= 1'b0;
      x_cmd  <= 1'b0;
    end else if (advance) begin
      x_beat <= beat_d;
      x_hdr  <= cls.is_hdr;
      x_cmd  <= cls.is_cmd;
    end
  end

  // a beat's sot must agree with where the frame tracker says we are.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prot_err <= 1'b0;
    end else if (load && (cls.beat.sot != cls.first_exp)) begin
      prot_err <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trig_hit <= 1'b0;
      trig_cap <= '0;
    end else if (load && match && !trig_hit) begin
      trig_hit <= 1'b1;
      trig_cap <= beat_d.data;
    end
  end

  // the captured data belongs to the first hit and is never overwritten.
  a_cap_frozen: assert property (
    @(posedge clk) disable iff (!arst_n) trig_hit |=> $stable(trig_cap)
  ) else $error("trigger capture changed after the hit");

endmodule

// File: rtl/isf_tlv_decode.sv
`timescale 1ns/100ps

module isf_tlv_decode import isf_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  isf_beat_t head,
  input  logic      not_empty,
  input  logic      advance,
  output logic      pop,
  output isf_cls_t  cls
);

  logic      in_frame;
  logic      hdr;
  tlv_type_t tlv;
  isf_cls_t  cls_d;

  // the pipeline moves as a whole, so a beat is taken only when it can move on.
  assign pop = not_empty && advance;

  // the beat's own sot marks a header, wherever it falls.
  assign hdr = head.valid && head.sot;
  assign tlv = hdr ? tlv_type_t'(head.data[7:0]) : '0;

  always_comb begin
    cls_d.beat      = head;
    cls_d.is_hdr    = hdr;
    cls_d.is_cmd    = hdr && (tlv == TLV_CMD);
    cls_d.first_exp = !in_frame;
    cls_d.tlv       = tlv;
  end

  // frame position as seen from the beats actually consumed.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_frame <= 1'b0;
    end else if (pop) begin
      in_frame <= !head.eot;
    end
  end

  // with advance high and nothing to pop, a bubble enters the stage.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cls <= '0;
    end else if (advance) begin
      cls <= cls_d;
    end
  end

endmodule

// File: rtl/isf_ib_fifo.sv
`timescale 1ns/100ps

module isf_ib_fifo import isf_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  isf_beat_t wr_beat,
  input  logic      pop,
  output isf_beat_t head,
  output logic      not_empty,
  output logic      credit,
  output logic      ovfl
);

  isf_beat_t mem [IB_DEPTH];
  ib_ptr_t   wr_ptr;
  ib_ptr_t   rd_ptr;
  ib_cnt_t   count;
  logic      full;
  logic      push;
  logic      do_pop;

  assign full      = (count == ib_cnt_t'(IB_DEPTH));
  assign not_empty = (count != '0);
  assign push      = wr_beat.valid && !full;
  assign do_pop    = pop && not_empty;

  // every beat that leaves the buffer frees one slot at the sender.
  assign credit = do_pop;

  always_comb begin
    head       = mem[rd_ptr];
    head.valid = not_empty;
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a beat arriving while full means the sender ignored its credits.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ovfl <= 1'b0;
    end else if (wr_beat.valid && full) begin
      ovfl <= 1'b1;
    end
  end

  // decode must never ask for a beat that is not there.
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n) pop |-> not_empty
  ) else $error("pop while the inbound FIFO is empty");

  a_count_range: assert property (
    @(posedge clk) disable iff (!arst_n) count <= ib_cnt_t'(IB_DEPTH)
  ) else $error("inbound FIFO count above its depth");

endmodule

// File: rtl/isf_pkg.sv
package isf_pkg;

  // beat geometry.
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  // frame header fields.
  localparam int DBG_BIT = 63;

  // inbound buffer depth, also the sender's initial credit count.
  localparam int IB_DEPTH = 16;

  // credits the core holds toward the receiver after reset.
  localparam int OB_CREDITS = 4;

  typedef logic [DATA_W-1:0]              data_t;
  typedef logic [STRB_W-1:0]              strb_t;
  typedef logic [$clog2(STRB_W+1)-1:0]    bcnt_t;
  typedef logic [7:0]                     tlv_type_t;
  typedef logic [$clog2(IB_DEPTH)-1:0]    ib_ptr_t;
  typedef logic [$clog2(IB_DEPTH):0]      ib_cnt_t;
  typedef logic [$clog2(OB_CREDITS+1)-1:0] ob_cnt_t;

  localparam tlv_type_t TLV_CMD = 8'd1;

  // one stream beat as it travels on both ports and inside the core.
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  sot;
    logic  eot;
    logic  valid;
  } isf_beat_t;

  // decode result handed to the execute stage.
  typedef struct packed {
    isf_beat_t beat;
    logic      is_hdr;
    logic      is_cmd;
    logic      first_exp;
    tlv_type_t tlv;
  } isf_cls_t;

  // statistics strobes, one set per beat sent.
  typedef struct packed {
    logic  bytes_stb;
    bcnt_t bytes_amt;
    logic  frame_stb;
    logic  cmd_stb;
  } isf_stat_t;

endpackage
